//--- bus_arbiter.sv
// --------------------
// bus arbiter
// credit queues per master, round-robin grant
// --------------------

module bus_arbiter (
  input  logic                           clk_i,
  input  logic                           arst_n_i,

  input  logic                           m0_req_i,
  input  logic                           m0_we_i,
  input  logic [mcu_pkg::DATA_W-1:0]     m0_addr_i,
  input  logic [mcu_pkg::DATA_W-1:0]     m0_wdata_i,
  output logic                           m0_credit_o,

  input  logic                           m1_req_i,
  input  logic                           m1_we_i,
  input  logic [mcu_pkg::DATA_W-1:0]     m1_addr_i,
  input  logic [mcu_pkg::DATA_W-1:0]     m1_wdata_i,
  output logic                           m1_credit_o,

  output logic                           gnt_valid_o,
  output logic [mcu_pkg::MASTER_W-1:0]   gnt_master_o,
  output logic                           gnt_we_o,
  output logic [mcu_pkg::DATA_W-1:0]     gnt_addr_o,
  output logic [mcu_pkg::DATA_W-1:0]     gnt_wdata_o
);

  logic [mcu_pkg::NUM_MASTERS-1:0] req;
  logic [mcu_pkg::NUM_MASTERS-1:0] we_in;
  logic [mcu_pkg::DATA_W-1:0]      addr_in  [mcu_pkg::NUM_MASTERS];
  logic [mcu_pkg::DATA_W-1:0]      wdata_in [mcu_pkg::NUM_MASTERS];

  logic [mcu_pkg::NUM_MASTERS-1:0] not_empty;
  logic [mcu_pkg::NUM_MASTERS-1:0] pop;
  logic [mcu_pkg::NUM_MASTERS-1:0] head_we;
  logic [mcu_pkg::DATA_W-1:0]      head_addr  [mcu_pkg::NUM_MASTERS];
  logic [mcu_pkg::DATA_W-1:0]      head_wdata [mcu_pkg::NUM_MASTERS];

  logic [mcu_pkg::MASTER_W-1:0] rr_q;
  logic [mcu_pkg::MASTER_W-1:0] gnt_sel;

  assign req         = {m1_req_i, m0_req_i};
  assign we_in       = {m1_we_i, m0_we_i};
  assign addr_in[0]  = m0_addr_i;
  assign addr_in[1]  = m1_addr_i;
  assign wdata_in[0] = m0_wdata_i;
  assign wdata_in[1] = m1_wdata_i;

  for (genvar m = 0; m < mcu_pkg::NUM_MASTERS; m++) begin : g_queue
    logic                       q_we    [mcu_pkg::REQ_QUEUE_DEPTH];
    logic [mcu_pkg::DATA_W-1:0] q_addr  [mcu_pkg::REQ_QUEUE_DEPTH];
    logic [mcu_pkg::DATA_W-1:0] q_wdata [mcu_pkg::REQ_QUEUE_DEPTH];
    logic [mcu_pkg::QPTR_W-1:0] wr_ptr;
    logic [mcu_pkg::QPTR_W-1:0] rd_ptr;
    logic [mcu_pkg::QCNT_W-1:0] count;

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (req[m]) wr_ptr <= wr_ptr + 1'b1;
        if (pop[m]) rd_ptr <= rd_ptr + 1'b1;
        case ({req[m], pop[m]})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;
        endcase
      end
    end

    always_ff @(posedge clk_i) begin
      if (req[m]) begin
        q_we[wr_ptr]    <= we_in[m];
        q_addr[wr_ptr]  <= addr_in[m];
        q_wdata[wr_ptr] <= wdata_in[m];
      end
    end

    assign not_empty[m]  = (count != '0);
    assign head_we[m]    = q_we[rd_ptr];
    assign head_addr[m]  = q_addr[rd_ptr];
    assign head_wdata[m] = q_wdata[rd_ptr];
    assign pop[m]        = gnt_valid_o && (gnt_sel == m);

    // a full queue only takes a push when it pops in the same cycle
    a_no_overflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      req[m] |-> (count < mcu_pkg::REQ_QUEUE_DEPTH) || pop[m]);

    // a credit only goes back for an entry that leaves the queue
    a_credit_with_grant : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      pop[m] |-> (count != '0));
  end

  // alternate when both wait, otherwise take whichever is ready
  always_comb begin
    if (&not_empty) gnt_sel = rr_q;
    else            gnt_sel = not_empty[1];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) rr_q <= '0;
    else if (gnt_valid_o) rr_q <= ~gnt_sel;
  end

  assign gnt_valid_o  = |not_empty;
  assign gnt_master_o = gnt_sel;
  assign gnt_we_o     = head_we[gnt_sel];
  assign gnt_addr_o   = head_addr[gnt_sel];
  assign gnt_wdata_o  = head_wdata[gnt_sel];

  assign m0_credit_o = pop[0];
  assign m1_credit_o = pop[1];

endmodule

//--- mcu_pkg.sv
// --------------------
// mini mcu package
// bus sizes, memory map, register indices, address views
// --------------------

package mcu_pkg;

  localparam int DATA_W = 32;

  localparam int NUM_MASTERS = 2;
  localparam int MASTER_W = $clog2(NUM_MASTERS);

  // queue depth is also the credit count after reset
  localparam int REQ_QUEUE_DEPTH = 2;
  localparam int QPTR_W = $clog2(REQ_QUEUE_DEPTH);
  localparam int QCNT_W = $clog2(REQ_QUEUE_DEPTH + 1);

  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = 8;

  localparam int REGION_W = 4;
  localparam int REG_IDX_W = 4;
  localparam int BYTE_OFF_W = 2;

  localparam logic [REGION_W-1:0] REGION_RAM = 4'h0;
  localparam logic [REGION_W-1:0] REGION_PERIPH = 4'h2;

  localparam logic [REG_IDX_W-1:0] REG_EXIT = 4'd0;
  localparam logic [REG_IDX_W-1:0] REG_GPIO_OUT = 4'd1;
  localparam logic [REG_IDX_W-1:0] REG_GPIO_EN = 4'd2;
  localparam logic [REG_IDX_W-1:0] REG_GPIO_IN = 4'd3;

  // one address word, seen by the RAM or by the register block
  typedef union packed {
    struct packed {
      logic [REGION_W-1:0]                                 region;
      logic [DATA_W-REGION_W-MEM_IDX_W-BYTE_OFF_W-1:0]     rsvd;
      logic [MEM_IDX_W-1:0]                                word_idx;
      logic [BYTE_OFF_W-1:0]                               byte_off;
    } ram;
    struct packed {
      logic [REGION_W-1:0]                                 region;
      logic [DATA_W-REGION_W-REG_IDX_W-BYTE_OFF_W-1:0]     rsvd;
      logic [REG_IDX_W-1:0]                                reg_idx;
      logic [BYTE_OFF_W-1:0]                               byte_off;
    } per;
  } bus_addr_u;

endpackage

//--- mini_mcu.sv
// --------------------
// mini mcu top level
// bus, RAM and peripherals
// --------------------

module mini_mcu (
  input  logic                        clk_i,
  input  logic                        arst_n_i,

  input  logic                        m0_req_i,
  input  logic                        m0_we_i,
  input  logic [mcu_pkg::DATA_W-1:0]  m0_addr_i,
  input  logic [mcu_pkg::DATA_W-1:0]  m0_wdata_i,
  output logic                        m0_credit_o,
  output logic                        m0_rvalid_o,
  output logic [mcu_pkg::DATA_W-1:0]  m0_rdata_o,
  output logic                        m0_err_o,

  input  logic                        m1_req_i,
  input  logic                        m1_we_i,
  input  logic [mcu_pkg::DATA_W-1:0]  m1_addr_i,
  input  logic [mcu_pkg::DATA_W-1:0]  m1_wdata_i,
  output logic                        m1_credit_o,
  output logic                        m1_rvalid_o,
  output logic [mcu_pkg::DATA_W-1:0]  m1_rdata_o,
  output logic                        m1_err_o,

  output logic [mcu_pkg::DATA_W-1:0]  exit_value_o,
  output logic                        exit_valid_o,

  input  logic [mcu_pkg::DATA_W-1:0]  gpio_i,
  output logic [mcu_pkg::DATA_W-1:0]  gpio_o,
  output logic [mcu_pkg::DATA_W-1:0]  gpio_en_o
);

  // ram slave
  logic                           ram_req;
  logic                           ram_we;
  logic [mcu_pkg::MEM_IDX_W-1:0]  ram_idx;
  logic [mcu_pkg::DATA_W-1:0]     ram_wdata;
  logic [mcu_pkg::DATA_W-1:0]     ram_rdata;

  // peripheral slave
  logic                           per_req;
  logic                           per_we;
  logic [mcu_pkg::REG_IDX_W-1:0]  per_sel;
  logic [mcu_pkg::DATA_W-1:0]     per_wdata;
  logic [mcu_pkg::DATA_W-1:0]     per_rdata;

  system_bus system_bus_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .m0_req_i   (m0_req_i),
    .m0_we_i    (m0_we_i),
    .m0_addr_i  (m0_addr_i),
    .m0_wdata_i (m0_wdata_i),
    .m0_credit_o(m0_credit_o),
    .m0_rvalid_o(m0_rvalid_o),
    .m0_rdata_o (m0_rdata_o),
    .m0_err_o   (m0_err_o),
    .m1_req_i   (m1_req_i),
    .m1_we_i    (m1_we_i),
    .m1_addr_i  (m1_addr_i),
    .m1_wdata_i (m1_wdata_i),
    .m1_credit_o(m1_credit_o),
    .m1_rvalid_o(m1_rvalid_o),
    .m1_rdata_o (m1_rdata_o),
    .m1_err_o   (m1_err_o),
    .ram_req_o  (ram_req),
    .ram_we_o   (ram_we),
    .ram_idx_o  (ram_idx),
    .ram_wdata_o(ram_wdata),
    .ram_rdata_i(ram_rdata),
    .per_req_o  (per_req),
    .per_we_o   (per_we),
    .per_sel_o  (per_sel),
    .per_wdata_o(per_wdata),
    .per_rdata_i(per_rdata)
  );

  sram_bank sram_bank_i (
    .clk_i      (clk_i),
    .ram_req_i  (ram_req),
    .ram_we_i   (ram_we),
    .ram_idx_i  (ram_idx),
    .ram_wdata_i(ram_wdata),
    .ram_rdata_o(ram_rdata)
  );

  periph_regs periph_regs_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .per_req_i   (per_req),
    .per_we_i    (per_we),
    .per_sel_i   (per_sel),
    .per_wdata_i (per_wdata),
    .per_rdata_o (per_rdata),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o)
  );

endmodule

//--- periph_regs.sv
// --------------------
// peripheral registers
// exit value and GPIO block
// --------------------

module periph_regs (
  input  logic                            clk_i,
  input  logic                            arst_n_i,

  input  logic                            per_req_i,
  input  logic                            per_we_i,
  input  logic [mcu_pkg::REG_IDX_W-1:0]   per_sel_i,
  input  logic [mcu_pkg::DATA_W-1:0]      per_wdata_i,
  output logic [mcu_pkg::DATA_W-1:0]      per_rdata_o,

  output logic [mcu_pkg::DATA_W-1:0]      exit_value_o,
  output logic                            exit_valid_o,

  input  logic [mcu_pkg::DATA_W-1:0]      gpio_i,
  output logic [mcu_pkg::DATA_W-1:0]      gpio_o,
  output logic [mcu_pkg::DATA_W-1:0]      gpio_en_o
);

  logic [mcu_pkg::DATA_W-1:0] exit_value_q;
  logic                       exit_valid_q;
  logic [mcu_pkg::DATA_W-1:0] gpio_out_q;
  logic [mcu_pkg::DATA_W-1:0] gpio_en_q;
  logic [mcu_pkg::DATA_W-1:0] gpio_meta_q;
  logic [mcu_pkg::DATA_W-1:0] gpio_sync_q;
  logic [mcu_pkg::DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      gpio_out_q   <= '0;
      gpio_en_q    <= '0;
      gpio_meta_q  <= '0;
      gpio_sync_q  <= '0;
    end else begin
      // two-flop input synchroniser
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
      if (per_req_i && per_we_i) begin
        case (per_sel_i)
          mcu_pkg::REG_EXIT: begin
            exit_value_q <= per_wdata_i;
            exit_valid_q <= 1'b1;
          end
          mcu_pkg::REG_GPIO_OUT: gpio_out_q <= per_wdata_i;
          mcu_pkg::REG_GPIO_EN:  gpio_en_q  <= per_wdata_i;
          default: ;
        endcase
      end
    end
  end

  // read data one cycle after the request
  always_ff @(posedge clk_i) begin
    if (per_req_i && !per_we_i) begin
      case (per_sel_i)
        mcu_pkg::REG_EXIT:     rdata_q <= exit_value_q;
        mcu_pkg::REG_GPIO_OUT: rdata_q <= gpio_out_q;
        mcu_pkg::REG_GPIO_EN:  rdata_q <= gpio_en_q;
        mcu_pkg::REG_GPIO_IN:  rdata_q <= gpio_sync_q;
        default:               rdata_q <= '0;
      endcase
    end
  end

  assign per_rdata_o  = rdata_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;
  assign gpio_o       = gpio_out_q;
  assign gpio_en_o    = gpio_en_q;

  a_exit_sticky : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exit_valid_o |=> exit_valid_o);

endmodule

//--- run.sh
#!/bin/sh
# build and run the mini mcu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_mini_mcu -o tb_mini_mcu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_mini_mcu 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- sim.f
mcu_pkg.sv
bus_arbiter.sv
system_bus.sv
sram_bank.sv
periph_regs.sv
mini_mcu.sv
tb_mini_mcu.sv

//--- sram_bank.sv
// --------------------
// sram bank
// word RAM, one cycle read latency
// --------------------

module sram_bank (
  input  logic                            clk_i,
  input  logic                            ram_req_i,
  input  logic                            ram_we_i,
  input  logic [mcu_pkg::MEM_IDX_W-1:0]   ram_idx_i,
  input  logic [mcu_pkg::DATA_W-1:0]      ram_wdata_i,
  output logic [mcu_pkg::DATA_W-1:0]      ram_rdata_o
);

  logic [mcu_pkg::DATA_W-1:0] mem [mcu_pkg::MEM_WORDS];
  logic [mcu_pkg::DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (ram_req_i) begin
      if (ram_we_i) begin
        mem[ram_idx_i] <= ram_wdata_i;
      end else begin
        rdata_q <= mem[ram_idx_i];
      end
    end
  end

  // holds the last read word until the next read
  assign ram_rdata_o = rdata_q;

endmodule

//--- system_bus.sv
// --------------------
// system bus
// decode, slave routing, response steering
// --------------------

module system_bus (
  input  logic                            clk_i,
  input  logic                            arst_n_i,

  input  logic                            m0_req_i,
  input  logic                            m0_we_i,
  input  logic [mcu_pkg::DATA_W-1:0]      m0_addr_i,
  input  logic [mcu_pkg::DATA_W-1:0]      m0_wdata_i,
  output logic                            m0_credit_o,
  output logic                            m0_rvalid_o,
  output logic [mcu_pkg::DATA_W-1:0]      m0_rdata_o,
  output logic                            m0_err_o,

  input  logic                            m1_req_i,
  input  logic                            m1_we_i,
  input  logic [mcu_pkg::DATA_W-1:0]      m1_addr_i,
  input  logic [mcu_pkg::DATA_W-1:0]      m1_wdata_i,
  output logic                            m1_credit_o,
  output logic                            m1_rvalid_o,
  output logic [mcu_pkg::DATA_W-1:0]      m1_rdata_o,
  output logic                            m1_err_o,

  output logic                            ram_req_o,
  output logic                            ram_we_o,
  output logic [mcu_pkg::MEM_IDX_W-1:0]   ram_idx_o,
  output logic [mcu_pkg::DATA_W-1:0]      ram_wdata_o,
  input  logic [mcu_pkg::DATA_W-1:0]      ram_rdata_i,

  output logic                            per_req_o,
  output logic                            per_we_o,
  output logic [mcu_pkg::REG_IDX_W-1:0]   per_sel_o,
  output logic [mcu_pkg::DATA_W-1:0]      per_wdata_o,
  input  logic [mcu_pkg::DATA_W-1:0]      per_rdata_i
);

  logic                         gnt_valid;
  logic [mcu_pkg::MASTER_W-1:0] gnt_master;
  logic                         gnt_we;
  mcu_pkg::bus_addr_u           gnt_addr;
  logic [mcu_pkg::DATA_W-1:0]   gnt_wdata;

  logic is_ram;
  logic is_per;

  // slaves answer one cycle after the grant
  logic                         rsp_valid_q;
  logic [mcu_pkg::MASTER_W-1:0] rsp_master_q;
  logic                         rsp_err_q;
  logic                         rsp_ram_q;
  logic                         rsp_we_q;
  logic [mcu_pkg::DATA_W-1:0]   rsp_rdata;

  bus_arbiter bus_arbiter_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .m0_req_i    (m0_req_i),
    .m0_we_i     (m0_we_i),
    .m0_addr_i   (m0_addr_i),
    .m0_wdata_i  (m0_wdata_i),
    .m0_credit_o (m0_credit_o),
    .m1_req_i    (m1_req_i),
    .m1_we_i     (m1_we_i),
    .m1_addr_i   (m1_addr_i),
    .m1_wdata_i  (m1_wdata_i),
    .m1_credit_o (m1_credit_o),
    .gnt_valid_o (gnt_valid),
    .gnt_master_o(gnt_master),
    .gnt_we_o    (gnt_we),
    .gnt_addr_o  (gnt_addr),
    .gnt_wdata_o (gnt_wdata)
  );

  assign is_ram = gnt_valid && (gnt_addr.ram.region == mcu_pkg::REGION_RAM);
  assign is_per = gnt_valid && (gnt_addr.per.region == mcu_pkg::REGION_PERIPH);

  assign ram_req_o   = is_ram;
  assign ram_we_o    = gnt_we;
  assign ram_idx_o   = gnt_addr.ram.word_idx;
  assign ram_wdata_o = gnt_wdata;

  assign per_req_o   = is_per;
  assign per_we_o    = gnt_we;
  assign per_sel_o   = gnt_addr.per.reg_idx;
  assign per_wdata_o = gnt_wdata;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q  <= 1'b0;
      rsp_master_q <= '0;
      rsp_err_q    <= 1'b0;
      rsp_ram_q    <= 1'b0;
      rsp_we_q     <= 1'b0;
    end else begin
      rsp_valid_q  <= gnt_valid;
      rsp_master_q <= gnt_master;
      rsp_err_q    <= gnt_valid && !is_ram && !is_per;
      rsp_ram_q    <= is_ram;
      rsp_we_q     <= gnt_we;
    end
  end

  // writes and unmapped accesses return zero
  assign rsp_rdata = (rsp_err_q || rsp_we_q) ? '0 :
                     (rsp_ram_q ? ram_rdata_i : per_rdata_i);

  assign m0_rvalid_o = rsp_valid_q && (rsp_master_q == 1'b0);
  assign m1_rvalid_o = rsp_valid_q && (rsp_master_q == 1'b1);
  assign m0_err_o    = m0_rvalid_o && rsp_err_q;
  assign m1_err_o    = m1_rvalid_o && rsp_err_q;
  assign m0_rdata_o  = rsp_rdata;
  assign m1_rdata_o  = rsp_rdata;

  // each grant ends in exactly one rvalid, on the granted master
  a_one_rvalid : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    gnt_valid |=> $onehot({m1_rvalid_o, m0_rvalid_o})
                  && (m1_rvalid_o == $past(gnt_master)));

endmodule

//--- tb_mini_mcu.sv
// --------------------
// mini mcu testbench
// reference model, credit-aware drivers, response checks
// --------------------

module tb_mini_mcu;

  localparam int TIMEOUT_CYCLES = 400;
  localparam int DW = mcu_pkg::DATA_W;

  logic          clk_i = 1'b0;
  logic          arst_n_i;
  logic [1:0]    req;
  logic [1:0]    we;
  logic [DW-1:0] addr [2];
  logic [DW-1:0] wdata [2];
  logic [1:0]    credit;
  logic [1:0]    rvalid;
  logic [1:0]    err;
  logic [DW-1:0] rdata [2];
  logic [DW-1:0] exit_value;
  logic          exit_valid;
  logic [DW-1:0] gpio_in;
  logic [DW-1:0] gpio_out;
  logic [DW-1:0] gpio_en;

  // reference model state
  logic [DW-1:0] ram_m [mcu_pkg::MEM_WORDS];
  logic [DW-1:0] exit_value_m;
  logic          exit_valid_m;
  logic [DW-1:0] gpio_out_m;
  logic [DW-1:0] gpio_en_m;
  logic [DW-1:0] gpio_in_m;

  // expected entries are {check, err, rdata}
  logic [DW+1:0] exp_q0 [$];
  logic [DW+1:0] exp_q1 [$];
  int            issued [2];
  int            returned [2];
  int            rsp_cnt [2];
  logic [DW-1:0] last_rdata [2];
  logic [31:0]   rng_state;

  always #50 clk_i = ~clk_i;

  mini_mcu dut_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .m0_req_i    (req[0]),
    .m0_we_i     (we[0]),
    .m0_addr_i   (addr[0]),
    .m0_wdata_i  (wdata[0]),
    .m0_credit_o (credit[0]),
    .m0_rvalid_o (rvalid[0]),
    .m0_rdata_o  (rdata[0]),
    .m0_err_o    (err[0]),
    .m1_req_i    (req[1]),
    .m1_we_i     (we[1]),
    .m1_addr_i   (addr[1]),
    .m1_wdata_i  (wdata[1]),
    .m1_credit_o (credit[1]),
    .m1_rvalid_o (rvalid[1]),
    .m1_rdata_o  (rdata[1]),
    .m1_err_o    (err[1]),
    .exit_value_o(exit_value),
    .exit_valid_o(exit_valid),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_out),
    .gpio_en_o   (gpio_en)
  );

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // returns {err, rdata} and applies writes to the model
  function automatic logic [DW:0] ref_access(input logic wr, input mcu_pkg::bus_addr_u a,
                                             input logic [DW-1:0] wd);
    logic [DW:0] res;
    res = '0;
    if (a.ram.region == mcu_pkg::REGION_RAM) begin
      if (wr) ram_m[a.ram.word_idx] = wd;
      else res[DW-1:0] = ram_m[a.ram.word_idx];
    end else if (a.per.region == mcu_pkg::REGION_PERIPH) begin
      if (wr) begin
        case (a.per.reg_idx)
          mcu_pkg::REG_EXIT: begin
            exit_value_m = wd;
            exit_valid_m = 1'b1;
          end
          mcu_pkg::REG_GPIO_OUT: gpio_out_m = wd;
          mcu_pkg::REG_GPIO_EN:  gpio_en_m = wd;
          default: ;
        endcase
      end else begin
        case (a.per.reg_idx)
          mcu_pkg::REG_EXIT:     res[DW-1:0] = exit_value_m;
          mcu_pkg::REG_GPIO_OUT: res[DW-1:0] = gpio_out_m;
          mcu_pkg::REG_GPIO_EN:  res[DW-1:0] = gpio_en_m;
          mcu_pkg::REG_GPIO_IN:  res[DW-1:0] = gpio_in_m;
          default:               res[DW-1:0] = '0;
        endcase
      end
    end else begin
      res[DW] = 1'b1;
    end
    return res;
  endfunction

  function automatic mcu_pkg::bus_addr_u ram_addr(input logic [mcu_pkg::MEM_IDX_W-1:0] idx);
    mcu_pkg::bus_addr_u a;
    a = xorshift();
    a.ram.region = mcu_pkg::REGION_RAM;
    a.ram.word_idx = idx;
    return a;
  endfunction

  function automatic mcu_pkg::bus_addr_u reg_addr(input logic [mcu_pkg::REG_IDX_W-1:0] sel);
    mcu_pkg::bus_addr_u a;
    a = xorshift();
    a.per.region = mcu_pkg::REGION_PERIPH;
    a.per.reg_idx = sel;
    return a;
  endfunction

  function automatic int credits(input int m);
    return mcu_pkg::REQ_QUEUE_DEPTH - issued[m] + returned[m];
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("tests failed");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_word(input string what, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  task automatic check_resp(input int m, input logic [DW-1:0] got_data, input logic got_err,
                            input logic [DW-1:0] exp_data, input logic exp_err);
    if (got_data !== exp_data || got_err !== exp_err) begin
      $display("Fail at %0t: m%0d response %h err %b, expected %h err %b",
               $time, m, got_data, got_err, exp_data, exp_err);
      stop_with_failure("response mismatch");
    end
  endtask

  task automatic take_response(input int m);
    logic [DW+1:0] ent;
    int            pending;
    pending = (m == 0) ? exp_q0.size() : exp_q1.size();
    if (rsp_cnt[m] >= pending) stop_with_failure("response without an outstanding request");
    ent = (m == 0) ? exp_q0[rsp_cnt[m]] : exp_q1[rsp_cnt[m]];
    rsp_cnt[m]++;
    last_rdata[m] = rdata[m];
    if (ent[DW+1]) check_resp(m, rdata[m], err[m], ent[DW-1:0], ent[DW]);
  endtask

  // outputs are sampled mid-cycle
  always @(negedge clk_i) begin
    for (int m = 0; m < 2; m++) begin
      if (!arst_n_i) begin
        returned[m] = 0;
        rsp_cnt[m] = 0;
      end else begin
        if (credit[m]) returned[m]++;
        if (rvalid[m]) take_response(m);
      end
    end
  end

  // called in the drive phase, leaves the caller in the next drive phase
  task automatic issue(input int m, input logic wr, input mcu_pkg::bus_addr_u a,
                       input logic [DW-1:0] wd, input logic chk);
    int waited;
    waited = 0;
    while (credits(m) == 0) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > TIMEOUT_CYCLES) stop_with_failure("timeout waiting for a bus credit");
    end
    if (m == 0) exp_q0.push_back({chk, ref_access(wr, a, wd)});
    else exp_q1.push_back({chk, ref_access(wr, a, wd)});
    issued[m]++;
    req[m] = 1'b1;
    we[m] = wr;
    addr[m] = a;
    wdata[m] = wd;
    @(posedge clk_i);
    #1;
    req[m] = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (rsp_cnt[0] != exp_q0.size() || rsp_cnt[1] != exp_q1.size()) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > TIMEOUT_CYCLES) stop_with_failure("timeout waiting for bus responses");
    end
  endtask

  // each master keeps its random RAM traffic in its own half
  task automatic traffic(input int m);
    logic [31:0]                  rnd;
    logic [mcu_pkg::MEM_IDX_W-1:0] idx;
    repeat (40) begin
      rnd = xorshift();
      idx = rnd[mcu_pkg::MEM_IDX_W-1:0];
      idx[mcu_pkg::MEM_IDX_W-1] = (m == 1);
      issue(m, rnd[31], ram_addr(idx), xorshift(), 1'b1);
    end
  endtask

  initial begin
    mcu_pkg::bus_addr_u            a;
    logic [31:0]                   rnd;
    int                            tries;
    logic                          found;
    logic [mcu_pkg::MEM_IDX_W-1:0] hit_idx [$];
    rng_state = 32'hafb2_3a2d;
    arst_n_i = 1'b0;
    req = '0;
    we = '0;
    gpio_in = '0;
    for (int m = 0; m < 2; m++) begin
      addr[m] = '0;
      wdata[m] = '0;
      issued[m] = 0;
    end
    exit_value_m = '0;
    exit_valid_m = 1'b0;
    gpio_out_m = '0;
    gpio_en_m = '0;
    gpio_in_m = '0;
    repeat (8) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    repeat (2) begin
      @(posedge clk_i);
      #1;
      for (int m = 0; m < 2; m++) begin
        check_bit("rvalid after reset", rvalid[m], 1'b0);
        check_bit("credit after reset", credit[m], 1'b0);
      end
      check_bit("exit_valid_o after reset", exit_valid, 1'b0);
      check_word("gpio_o after reset", gpio_out, '0);
      check_word("gpio_en_o after reset", gpio_en, '0);
    end

    // fill the whole RAM, then random writes and reads per master
    for (int i = 0; i < mcu_pkg::MEM_WORDS; i++) begin
      issue(0, 1'b1, ram_addr(i[mcu_pkg::MEM_IDX_W-1:0]), xorshift(), 1'b1);
    end
    for (int m = 0; m < 2; m++) begin
      repeat (16) begin
        rnd = xorshift();
        issue(m, 1'b1, ram_addr(rnd[7:0]), xorshift(), 1'b1);
      end
      repeat (16) begin
        rnd = xorshift();
        issue(m, 1'b0, ram_addr(rnd[7:0]), '0, 1'b1);
      end
    end
    wait_idle();

    fork
      traffic(0);
      traffic(1);
    join
    wait_idle();
    check_word("m0 credits", DW'(credits(0)), DW'(mcu_pkg::REQ_QUEUE_DEPTH));
    check_word("m1 credits", DW'(credits(1)), DW'(mcu_pkg::REQ_QUEUE_DEPTH));

    issue(0, 1'b1, reg_addr(mcu_pkg::REG_GPIO_OUT), xorshift(), 1'b1);
    issue(0, 1'b1, reg_addr(mcu_pkg::REG_GPIO_EN), xorshift(), 1'b1);
    issue(1, 1'b0, reg_addr(mcu_pkg::REG_GPIO_OUT), '0, 1'b1);
    issue(1, 1'b0, reg_addr(mcu_pkg::REG_GPIO_EN), '0, 1'b1);
    wait_idle();
    check_word("gpio_o", gpio_out, gpio_out_m);
    check_word("gpio_en_o", gpio_en, gpio_en_m);

    // poll until the synchroniser has passed the new input
    gpio_in = xorshift();
    gpio_in_m = gpio_in;
    tries = 0;
    found = 1'b0;
    while (!found) begin
      issue(1, 1'b0, reg_addr(mcu_pkg::REG_GPIO_IN), '0, 1'b0);
      wait_idle();
      tries++;
      if (last_rdata[1] === gpio_in_m) found = 1'b1;
      else if (tries > 10) stop_with_failure("GPIO input never reached its register");
    end

    issue(0, 1'b1, reg_addr(mcu_pkg::REG_EXIT), xorshift(), 1'b1);
    issue(1, 1'b0, reg_addr(mcu_pkg::REG_EXIT), '0, 1'b1);
    wait_idle();
    check_bit("exit_valid_o", exit_valid, 1'b1);
    check_word("exit_value_o", exit_value, exit_value_m);

    repeat (12) begin
      a = xorshift();
      if (a.ram.region == mcu_pkg::REGION_RAM || a.ram.region == mcu_pkg::REGION_PERIPH) begin
        a.ram.region = 4'hf;
      end
      hit_idx.push_back(a.ram.word_idx);
      rnd = xorshift();
      issue(int'(rnd[1]), rnd[0], a, xorshift(), 1'b1);
    end
    wait_idle();
    // nothing above may have touched RAM or registers
    foreach (hit_idx[i]) begin
      issue(0, 1'b0, ram_addr(hit_idx[i]), '0, 1'b1);
    end
    issue(1, 1'b0, reg_addr(mcu_pkg::REG_GPIO_OUT), '0, 1'b1);
    wait_idle();
    check_word("gpio_o", gpio_out, gpio_out_m);
    check_word("gpio_en_o", gpio_en, gpio_en_m);
    check_bit("exit_valid_o", exit_valid, 1'b1);
    check_word("exit_value_o", exit_value, exit_value_m);
    check_word("m0 credits", DW'(credits(0)), DW'(mcu_pkg::REQ_QUEUE_DEPTH));
    check_word("m1 credits", DW'(credits(1)), DW'(mcu_pkg::REQ_QUEUE_DEPTH));

    $display("all tests passed");
    $finish;
  end

endmodule
